// ==== periph_bus_wrap.f ====
logic/apb_pkg.sv
logic/periph_map_pkg.sv
logic/apb_node.sv
logic/gpio_regs.sv
logic/timer_regs.sv
logic/periph_bus_wrap.sv
test/tb_periph_bus_wrap.sv

// ==== Makefile ====
# Verilator build and run for the peripheral bus wrapper testbench

VERILATOR ?= verilator
TOP       := tb_periph_bus_wrap
FILELIST  := periph_bus_wrap.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the log decides pass or fail, since tee hides the simulator's exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_periph_bus_wrap.sv ====
/*
 * Testbench for the peripheral bus wrapper
 * Directed APB transfers to the GPIO and timer blocks and to unmapped
 * addresses, with results checked against the register map
 */

`timescale 1ns/1ps

module tb_periph_bus_wrap;

    import apb_pkg::*;
    import periph_map_pkg::*;

    localparam int unsigned NUM_GPIO       = 16;
    localparam int unsigned CLK_PERIOD     = 100;
    localparam int unsigned DRIVE_DELAY    = 10;
    // the whole sequence needs a few hundred cycles, so this leaves a wide margin
    localparam int unsigned TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] SEED           = 32'hdf88dc46;
    localparam data_t       GPIO_MASK      = 32'hFFFF_FFFF >> (32 - NUM_GPIO);

    logic                clk;
    logic                rst_n;
    apb_req_t            apb_req;
    apb_resp_t           apb_resp;
    logic [NUM_GPIO-1:0] gpio_in;
    logic [NUM_GPIO-1:0] gpio_out;
    logic [NUM_GPIO-1:0] gpio_oe;
    logic                timer_event;
    logic [31:0]         rng;
    data_t               gpio_out_exp;
    data_t               gpio_dir_exp;
    int unsigned         event_count = 0;
    int unsigned         cycles;
    int unsigned         access_cycles;

    periph_bus_wrap #(
        .NUM_GPIO ( NUM_GPIO )
    ) i_dut (
        .clk_i       ( clk         ),
        .rst_n       ( rst_n       ),
        .apb_req     ( apb_req     ),
        .apb_resp    ( apb_resp    ),
        .gpio_in     ( gpio_in     ),
        .gpio_out    ( gpio_out    ),
        .gpio_oe     ( gpio_oe     ),
        .timer_event ( timer_event )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // the event is high for one whole cycle, so one sample per cycle counts it once
    always @(negedge clk) begin
        if (rst_n && timer_event) begin
            event_count <= event_count + 1;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        fail_stop($sformatf("timeout: the run hung, tests not done after %0d cycles",
                            TIMEOUT_CYCLES));
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic addr_t gpio_reg(input logic [OFS_WIDTH-1:0] ofs);
        return GPIO_BASE + addr_t'(ofs);
    endfunction

    function automatic addr_t timer_reg(input logic [OFS_WIDTH-1:0] ofs);
        return TIMER_BASE + addr_t'(ofs);
    endfunction

    // the timer adds one wait state, GPIO and unmapped addresses answer at once
    function automatic int unsigned access_len(input addr_t addr);
        if (addr >= TIMER_BASE && addr < TIMER_BASE + TIMER_LENGTH) begin
            return 2;
        end
        return 1;
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            fail_stop($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // compares the error bit of a completed transfer
    task automatic check_resp(input string name, input logic exp_err, input apb_resp_t act);
        if (act.pslverr !== exp_err) begin
            fail_stop($sformatf("[ERROR] %s: expected pslverr %b, actual %b",
                                name, exp_err, act.pslverr));
        end
    endtask

    task automatic check_pins(input string name, input logic [NUM_GPIO-1:0] exp,
                              input logic [NUM_GPIO-1:0] act);
        if (exp !== act) begin
            fail_stop($sformatf("[ERROR] %s: expected pins %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_cycles(input string name, input int unsigned exp,
                                input int unsigned act);
        if (exp != act) begin
            fail_stop($sformatf("[ERROR] %s: expected %0d access cycles, actual %0d",
                                name, exp, act));
        end
    endtask

    task automatic check_above(input string name, input data_t bound, input data_t act);
        if (!(act > bound)) begin
            fail_stop($sformatf("[ERROR] %s: expected above %h, actual %h", name, bound, act));
        end
    endtask

    task automatic check_at_most(input string name, input data_t bound, input data_t act);
        if (!(act <= bound)) begin
            fail_stop($sformatf("[ERROR] %s: expected at most %h, actual %h", name, bound, act));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
    endtask

    // setup cycle, then access cycles until pready, then back to idle
    task automatic apb_transfer(input addr_t addr, input data_t wdata, input logic write,
                                output apb_resp_t resp);
        @(posedge clk);
        #(DRIVE_DELAY);
        apb_req = '{paddr: addr, pwdata: wdata, pwrite: write, psel: 1'b1, penable: 1'b0};
        @(posedge clk);
        #(DRIVE_DELAY);
        apb_req.penable = 1'b1;
        access_cycles = 0;
        do begin
            @(negedge clk);
            access_cycles++;
        end while (apb_resp.pready !== 1'b1);
        resp = apb_resp;
        @(posedge clk);
        #(DRIVE_DELAY);
        apb_req = '0;
    endtask

    task automatic apb_write(input addr_t addr, input data_t wdata, output apb_resp_t resp);
        apb_transfer(addr, wdata, 1'b1, resp);
    endtask

    task automatic apb_read(input addr_t addr, output apb_resp_t resp);
        apb_transfer(addr, '0, 1'b0, resp);
    endtask

    task automatic write_ok(input string name, input addr_t addr, input data_t wdata);
        apb_resp_t resp;
        apb_write(addr, wdata, resp);
        check_resp(name, 1'b0, resp);
        check_cycles(name, access_len(addr), access_cycles);
    endtask

    task automatic read_expect(input string name, input addr_t addr, input data_t exp);
        apb_resp_t resp;
        apb_read(addr, resp);
        check_resp(name, 1'b0, resp);
        check_cycles(name, access_len(addr), access_cycles);
        check_data(name, exp, resp.prdata);
    endtask

    task automatic test_reset_state();
        check_pins("reset_state", '0, gpio_out);
        check_pins("reset_state", '0, gpio_oe);
        check_data("reset_state", '0, data_t'(timer_event));
        read_expect("reset_state", gpio_reg(GPIO_OUT_OFS), '0);
        read_expect("reset_state", gpio_reg(GPIO_DIR_OFS), '0);
        read_expect("reset_state", gpio_reg(GPIO_IN_OFS), '0);
        read_expect("reset_state", timer_reg(TMR_CTRL_OFS), '0);
        read_expect("reset_state", timer_reg(TMR_COUNT_OFS), '0);
        read_expect("reset_state", timer_reg(TMR_CMP_OFS), '0);
        read_expect("reset_state", timer_reg(TMR_STATUS_OFS), '0);
    endtask

    task automatic test_gpio_rw();
        rng = xorshift32(rng);
        gpio_out_exp = rng;
        rng = xorshift32(rng);
        gpio_dir_exp = rng;
        write_ok("gpio_rw", gpio_reg(GPIO_OUT_OFS), gpio_out_exp);
        check_pins("gpio_rw", gpio_out_exp[NUM_GPIO-1:0], gpio_out);
        write_ok("gpio_rw", gpio_reg(GPIO_DIR_OFS), gpio_dir_exp);
        check_pins("gpio_rw", gpio_dir_exp[NUM_GPIO-1:0], gpio_oe);
        read_expect("gpio_rw", gpio_reg(GPIO_OUT_OFS), gpio_out_exp & GPIO_MASK);
        read_expect("gpio_rw", gpio_reg(GPIO_DIR_OFS), gpio_dir_exp & GPIO_MASK);
    endtask

    task automatic test_gpio_input();
        logic [NUM_GPIO-1:0] pins;
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            pins = rng[NUM_GPIO-1:0];
            gpio_in = pins;
            // two synchronizer flops lie between the pins and the register
            repeat (4) @(posedge clk);
            #(DRIVE_DELAY);
            read_expect("gpio_input", gpio_reg(GPIO_IN_OFS), data_t'(pins));
        end
    endtask

    task automatic test_addr_miss();
        apb_resp_t resp;
        rng = xorshift32(rng);
        // just past the GPIO window, and inside the gap above the timer window
        apb_read(32'h1A10_2000, resp);
        check_resp("addr_miss", 1'b1, resp);
        check_cycles("addr_miss", 1, access_cycles);
        check_data("addr_miss", '0, resp.prdata);
        apb_write(32'h1A10_2000, rng, resp);
        check_resp("addr_miss", 1'b1, resp);
        check_cycles("addr_miss", 1, access_cycles);
        check_data("addr_miss", '0, resp.prdata);
        apb_write(32'h1A10_C008, rng, resp);
        check_resp("addr_miss", 1'b1, resp);
        check_cycles("addr_miss", 1, access_cycles);
        check_pins("addr_miss", gpio_out_exp[NUM_GPIO-1:0], gpio_out);
        check_pins("addr_miss", gpio_dir_exp[NUM_GPIO-1:0], gpio_oe);
        read_expect("addr_miss", gpio_reg(GPIO_OUT_OFS), gpio_out_exp & GPIO_MASK);
        read_expect("addr_miss", gpio_reg(GPIO_DIR_OFS), gpio_dir_exp & GPIO_MASK);
        read_expect("addr_miss", timer_reg(TMR_CMP_OFS), '0);
    endtask

    task automatic test_timer_count();
        apb_resp_t resp;
        data_t     first;
        data_t     second;
        read_expect("timer_count", timer_reg(TMR_COUNT_OFS), '0);
        write_ok("timer_count", timer_reg(TMR_CMP_OFS), 32'hFFFF_FFFF);
        write_ok("timer_count", timer_reg(TMR_CTRL_OFS), 32'h1);
        apb_read(timer_reg(TMR_COUNT_OFS), resp);
        first = resp.prdata;
        apb_read(timer_reg(TMR_COUNT_OFS), resp);
        second = resp.prdata;
        check_above("timer_count", first, second);
        // the count is read only, so it keeps counting from where it was
        write_ok("timer_count", timer_reg(TMR_COUNT_OFS), 32'hF000_0000);
        apb_read(timer_reg(TMR_COUNT_OFS), resp);
        check_above("timer_count", second, resp.prdata);
        check_at_most("timer_count", 32'hEFFF_FFFF, resp.prdata);
    endtask

    task automatic test_timer_match();
        apb_resp_t   resp;
        int unsigned events_before;
        apply_reset();
        events_before = event_count;
        write_ok("timer_match", timer_reg(TMR_CMP_OFS), 32'd20);
        write_ok("timer_match", timer_reg(TMR_CTRL_OFS), 32'h1);
        // each timer read takes four cycles, so this spans about 100 cycles
        for (int i = 0; i < 25; i++) begin
            apb_read(timer_reg(TMR_COUNT_OFS), resp);
            check_at_most("timer_match", 32'd20, resp.prdata);
        end
        check_above("timer_match", '0, data_t'(event_count - events_before));
        // with the timer stopped no new match can set the flag again
        write_ok("timer_match", timer_reg(TMR_CTRL_OFS), 32'h0);
        read_expect("timer_match", timer_reg(TMR_STATUS_OFS), 32'h1);
        write_ok("timer_match", timer_reg(TMR_STATUS_OFS), 32'h1);
        read_expect("timer_match", timer_reg(TMR_STATUS_OFS), 32'h0);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        gpio_in = '0;
        rng     = SEED;
        apply_reset();
        test_reset_state();
        test_gpio_rw();
        test_gpio_input();
        test_addr_miss();
        test_timer_count();
        test_timer_match();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== logic/periph_bus_wrap.sv ====
/*
 * Peripheral bus wrapper
 * One APB slave port decoded onto the GPIO and timer register blocks
 */

`timescale 1ns/1ps

module periph_bus_wrap #(
    parameter int unsigned NUM_GPIO = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_n,
    input  apb_pkg::apb_req_t    apb_req,
    output apb_pkg::apb_resp_t   apb_resp,
    input  logic [NUM_GPIO-1:0]  gpio_in,
    output logic [NUM_GPIO-1:0]  gpio_out,
    output logic [NUM_GPIO-1:0]  gpio_oe,
    output logic                 timer_event
);

    import apb_pkg::*;
    import periph_map_pkg::*;

    // builds the start table, or the inclusive end table when last is set
    function automatic logic [NUM_TARGETS-1:0][ADDR_WIDTH-1:0] map_addr(input logic last);
        logic [NUM_TARGETS-1:0][ADDR_WIDTH-1:0] m;
        m            = '0;
        m[GPIO_IDX]  = last ? GPIO_BASE + GPIO_LENGTH - 1 : GPIO_BASE;
        m[TIMER_IDX] = last ? TIMER_BASE + TIMER_LENGTH - 1 : TIMER_BASE;
        return m;
    endfunction

    apb_req_t  [NUM_TARGETS-1:0] target_req;
    apb_resp_t [NUM_TARGETS-1:0] target_resp;

    apb_node #(
        .NB_TARGETS ( NUM_TARGETS     ),
        .START_ADDR ( map_addr(1'b0)  ),
        .END_ADDR   ( map_addr(1'b1)  )
    ) i_apb_node (
        .clk_i       ( clk_i       ),
        .rst_n       ( rst_n       ),
        .slave_req   ( apb_req     ),
        .slave_resp  ( apb_resp    ),
        .target_req  ( target_req  ),
        .target_resp ( target_resp )
    );

    gpio_regs #(
        .NUM_GPIO ( NUM_GPIO )
    ) i_gpio_regs (
        .clk_i    ( clk_i                  ),
        .rst_n    ( rst_n                  ),
        .req      ( target_req[GPIO_IDX]   ),
        .resp     ( target_resp[GPIO_IDX]  ),
        .gpio_in  ( gpio_in                ),
        .gpio_out ( gpio_out               ),
        .gpio_oe  ( gpio_oe                )
    );

    timer_regs i_timer_regs (
        .clk_i       ( clk_i                  ),
        .rst_n       ( rst_n                  ),
        .req         ( target_req[TIMER_IDX]  ),
        .resp        ( target_resp[TIMER_IDX] ),
        .timer_event ( timer_event            )
    );

endmodule

// ==== logic/timer_regs.sv ====
/*
 * Compare timer register block
 * Free-running counter that wraps at the compare value, with a sticky
 * match flag and a one-cycle event. The APB port adds one wait state
 */

`timescale 1ns/1ps

module timer_regs (
    input  logic                clk_i,
    input  logic                rst_n,
    input  apb_pkg::apb_req_t   req,
    output apb_pkg::apb_resp_t  resp,
    output logic                timer_event
);

    import apb_pkg::*;
    import periph_map_pkg::*;

    logic                  enable_q;
    logic [DATA_WIDTH-1:0] count_q;
    logic [DATA_WIDTH-1:0] cmp_q;
    logic                  match_q;
    logic                  event_q;
    logic                  wait_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic [DATA_WIDTH-1:0] rdata;
    logic [OFS_WIDTH-1:0]  ofs;
    logic                  first_cycle;
    logic                  wr_en;
    logic                  hit_cmp;

    assign ofs         = req.paddr[OFS_WIDTH-1:0];
    // first access cycle, where pready is still low
    assign first_cycle = req.psel & req.penable & ~wait_q;
    // writes take effect at the end of the second access cycle
    assign wr_en       = req.psel & req.penable & req.pwrite & wait_q;
    assign hit_cmp     = enable_q && (count_q == cmp_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= first_cycle;
        end
    end

    always_comb begin
        rdata = '0;
        case (ofs)
            TMR_CTRL_OFS:   rdata[0] = enable_q;
            TMR_COUNT_OFS:  rdata    = count_q;
            TMR_CMP_OFS:    rdata    = cmp_q;
            TMR_STATUS_OFS: rdata[0] = match_q;
            default:        rdata    = '0;
        endcase
    end

    // read data is sampled in the first cycle and returned in the second
    always_ff @(posedge clk_i) begin
        if (first_cycle) begin
            rdata_q <= rdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
            count_q  <= '0;
            cmp_q    <= '0;
            match_q  <= 1'b0;
            event_q  <= 1'b0;
        end else begin
            event_q <= hit_cmp;
            if (hit_cmp) begin
                count_q <= '0;
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_en && ofs == TMR_CTRL_OFS) begin
                enable_q <= req.pwdata[0];
            end
            if (wr_en && ofs == TMR_CMP_OFS) begin
                cmp_q <= req.pwdata;
            end
            // a new match wins over a clear in the same cycle
            if (hit_cmp) begin
                match_q <= 1'b1;
            end else if (wr_en && ofs == TMR_STATUS_OFS && req.pwdata[0]) begin
                match_q <= 1'b0;
            end
        end
    end

    assign resp.prdata  = rdata_q;
    assign resp.pready  = wait_q;
    assign resp.pslverr = 1'b0;
    assign timer_event  = event_q;

    // relies on the requester holding psel and penable through the wait state
    a_pready_in_access: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        resp.pready |-> (req.psel && req.penable)
    );

endmodule

// ==== logic/gpio_regs.sv ====
/*
 * GPIO register block
 * Output and direction registers plus a two-flop synchronized view
 * of the input pins, on an APB port with no wait states
 */

`timescale 1ns/1ps

module gpio_regs #(
    parameter int unsigned NUM_GPIO = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_n,
    input  apb_pkg::apb_req_t    req,
    output apb_pkg::apb_resp_t   resp,
    input  logic [NUM_GPIO-1:0]  gpio_in,
    output logic [NUM_GPIO-1:0]  gpio_out,
    output logic [NUM_GPIO-1:0]  gpio_oe
);

    import apb_pkg::*;
    import periph_map_pkg::*;

    logic [NUM_GPIO-1:0]  out_q;
    logic [NUM_GPIO-1:0]  oe_q;
    logic [NUM_GPIO-1:0]  in_meta_q;
    logic [NUM_GPIO-1:0]  in_sync_q;
    logic [OFS_WIDTH-1:0] ofs;
    logic                 access;
    logic [DATA_WIDTH-1:0] rdata;

    assign ofs    = req.paddr[OFS_WIDTH-1:0];
    assign access = req.psel & req.penable;

    // writes land on the edge that ends the single access cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            out_q <= '0;
            oe_q  <= '0;
        end else if (access && req.pwrite) begin
            if (ofs == GPIO_OUT_OFS) begin
                out_q <= req.pwdata[NUM_GPIO-1:0];
            end
            if (ofs == GPIO_DIR_OFS) begin
                oe_q <= req.pwdata[NUM_GPIO-1:0];
            end
        end
    end

    // pins are asynchronous to clk_i
    always_ff @(posedge clk_i) begin
        in_meta_q <= gpio_in;
        in_sync_q <= in_meta_q;
    end

    // unused offsets read as zero and still complete without error
    always_comb begin
        rdata = '0;
        case (ofs)
            GPIO_OUT_OFS: rdata[NUM_GPIO-1:0] = out_q;
            GPIO_DIR_OFS: rdata[NUM_GPIO-1:0] = oe_q;
            GPIO_IN_OFS:  rdata[NUM_GPIO-1:0] = in_sync_q;
            default:      rdata = '0;
        endcase
    end

    assign resp.prdata  = rdata;
    assign resp.pready  = access;
    assign resp.pslverr = 1'b0;

    assign gpio_out = out_q;
    assign gpio_oe  = oe_q;

    // an access phase only starts after a setup cycle, so psel is already high
    a_penable_needs_psel: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        $rose(req.penable) |-> req.psel
    );

endmodule

// ==== logic/apb_node.sv ====
/*
 * APB node
 * Decodes the slave port address against a table of windows, routes
 * the request to the matching target and returns its response.
 * A miss is answered here with an error and no wait state
 */

`timescale 1ns/1ps

module apb_node #(
    parameter int unsigned NB_TARGETS = 2,
    parameter logic [NB_TARGETS-1:0][apb_pkg::ADDR_WIDTH-1:0] START_ADDR = '0,
    parameter logic [NB_TARGETS-1:0][apb_pkg::ADDR_WIDTH-1:0] END_ADDR   = '0
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n,
    input  apb_pkg::apb_req_t                    slave_req,
    output apb_pkg::apb_resp_t                   slave_resp,
    output apb_pkg::apb_req_t  [NB_TARGETS-1:0]  target_req,
    input  apb_pkg::apb_resp_t [NB_TARGETS-1:0]  target_resp
);

    import apb_pkg::*;

    // completes in the first access cycle, reads as zero
    localparam apb_resp_t MISS_RESP = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};

    logic [NB_TARGETS-1:0] sel;
    logic                  hit;

    // the end address is inclusive
    always_comb begin
        for (int unsigned i = 0; i < NB_TARGETS; i++) begin
            sel[i] = (slave_req.paddr >= START_ADDR[i]) &&
                     (slave_req.paddr <= END_ADDR[i]);
        end
    end

    assign hit = |sel;

    // every target sees the same address and data, but only the
    // selected one sees psel and penable
    always_comb begin
        for (int unsigned i = 0; i < NB_TARGETS; i++) begin
            target_req[i]         = slave_req;
            target_req[i].psel    = slave_req.psel & sel[i];
            target_req[i].penable = slave_req.penable & sel[i];
        end
    end

    always_comb begin
        slave_resp = MISS_RESP;
        if (hit) begin
            slave_resp = '0;
            for (int unsigned i = 0; i < NB_TARGETS; i++) begin
                if (sel[i]) begin
                    slave_resp = target_resp[i];
                end
            end
        end
    end

    // overlapping windows in the top level map would select two targets
    a_sel_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        slave_req.psel |-> $onehot0(sel)
    );

endmodule

// ==== logic/periph_map_pkg.sv ====
/*
 * Peripheral address map
 * Window base and length of each decoded target, the target
 * indices on the node and the register offsets inside each window
 */

package periph_map_pkg;

    localparam int unsigned NUM_TARGETS = 2;
    localparam int unsigned GPIO_IDX    = 0;
    localparam int unsigned TIMER_IDX   = 1;

    localparam apb_pkg::addr_t GPIO_BASE    = 32'h1A10_1000;
    localparam apb_pkg::addr_t GPIO_LENGTH  = 32'h0000_1000;
    localparam apb_pkg::addr_t TIMER_BASE   = 32'h1A10_B000;
    localparam apb_pkg::addr_t TIMER_LENGTH = 32'h0000_1000;

    // both windows are 4 KiB, so the low 12 address bits pick the register
    localparam int unsigned OFS_WIDTH = 12;

    localparam logic [OFS_WIDTH-1:0] GPIO_OUT_OFS = 12'h000;
    localparam logic [OFS_WIDTH-1:0] GPIO_DIR_OFS = 12'h004;
    localparam logic [OFS_WIDTH-1:0] GPIO_IN_OFS  = 12'h008;

    localparam logic [OFS_WIDTH-1:0] TMR_CTRL_OFS   = 12'h000;
    localparam logic [OFS_WIDTH-1:0] TMR_COUNT_OFS  = 12'h004;
    localparam logic [OFS_WIDTH-1:0] TMR_CMP_OFS    = 12'h008;
    localparam logic [OFS_WIDTH-1:0] TMR_STATUS_OFS = 12'h00C;

endpackage

// ==== logic/apb_pkg.sv ====
/*
 * APB protocol definitions
 * Bus widths and the packed request and response structs that
 * carry one APB slave port between the wrapper, node and peripherals
 */

package apb_pkg;

    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // everything the requester drives, held stable through the access phase
    typedef struct packed {
        addr_t paddr;
        data_t pwdata;
        logic  pwrite;
        logic  psel;
        logic  penable;
    } apb_req_t;

    // everything the completer drives
    // prdata and pslverr only count while pready is high
    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_resp_t;

endpackage
